/* sim.f */
rtl/bpred_pkg.sv
rtl/instr_class.sv
rtl/btb.sv
rtl/pht.sv
rtl/pred_combine.sv
rtl/bimodal_top.sv
bench/bpred_chk.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the bimodal predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f sim.f

out=$(./obj_dir/Vtb_top)
echo "$out"

# The run passes only if the testbench printed the pass line
echo "$out" | grep -qx "NO ERRORS"

/* bench/tb_top.sv */
module tb_top;

    import bpred_pkg::*;

    localparam int          PHASE_LEN      = 300;
    localparam int          NUM_TESTS      = 6;
    localparam int          TIMEOUT_CYCLES = NUM_TESTS * PHASE_LEN + 200;
    localparam int          POOL_SIZE      = 16;
    localparam int          ALU_IDX        = 3;
    localparam logic [31:0] SEED           = 32'hf5874ccb;
    localparam addr_t       BASE_PC        = 32'h0040_0000;
    localparam addr_t       TGT_A          = 32'h0041_0000;
    localparam addr_t       TGT_B          = 32'h0041_0100;
    localparam addr_t       TGT_C          = 32'h0042_0000;
    localparam addr_t       TGT_D          = 32'h0043_0000;
    localparam addr_t       TGT_E          = 32'h0044_0000;
    localparam addr_t       TGT_F          = 32'h0045_0000;
    localparam addr_t       TGT_G          = 32'h0046_0000;

    logic     CLK;
    logic     RESET;
    logic     FLUSH;
    fetch_t   fetch;
    resolve_t resolve;
    pred_t    pred;

    int   test_id;
    logic test_end;
    int   total_checks;
    int   total_errors;
    int   assert_fails;
    int   cur_test;
    int   phase_cycles;
    int   cycle_count = 0;

    logic [31:0] rng_state;
    addr_t       pool_pc    [POOL_SIZE];
    instr_t      pool_instr [POOL_SIZE];

    tb_clock clk_gen (
        .CLK   (CLK),
        .RESET (RESET)
    );

    bimodal_top UUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .FLUSH   (FLUSH),
        .fetch   (fetch),
        .resolve (resolve),
        .pred    (pred)
    );

    tb_checker scoreboard (
        .CLK          (CLK),
        .RESET        (RESET),
        .FLUSH        (FLUSH),
        .fetch        (fetch),
        .resolve      (resolve),
        .pred         (pred),
        .test_id      (test_id),
        .test_end     (test_end),
        .total_checks (total_checks),
        .total_errors (total_errors)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper LCG bits are the better distributed ones
    function automatic int rand_slot();
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:28]);
    endfunction

    function automatic addr_t rand_target();
        logic [31:0] r;
        r = next_rand();
        return {8'h01, r[31:10], 2'b00};
    endfunction

    function automatic logic [5:0] branch_op(logic [2:0] sel);
        case (sel)
            3'd0: return OP_BEQ;
            3'd1: return OP_BNE;
            3'd2: return OP_BLEZ;
            3'd3: return OP_BGTZ;
            default: return OP_REGIMM;
        endcase
    endfunction

    function automatic instr_t jump_word(logic [31:0] r);
        case (r[1:0])
            2'd0: return {OP_J, r[25:0]};
            2'd1: return {OP_JAL, r[25:0]};
            default: return {OP_SPECIAL, r[25:21], 15'd0, FN_JR};
        endcase
    endfunction

    // Slots 12 to 15 share BTB indexes with slots 0 to 3 under another tag
    task automatic build_pool();
        logic [31:0] r;
        for (int i = 0; i < POOL_SIZE; i++) begin
            r = next_rand();
            if (i < 12) begin
                pool_pc[i] = BASE_PC + 32'(i) * 32'd4;
            end else begin
                pool_pc[i] = BASE_PC + 32'h100 + 32'(i - 12) * 32'd4;
            end
            case (i % 4)
                0, 1: pool_instr[i] = {branch_op(r[2:0]), r[25:0]};
                2: pool_instr[i] = jump_word(r);
                default: pool_instr[i] = {6'b001001, r[25:0]};
            endcase
        end
    endtask

    function automatic resolve_t make_res(addr_t pc, instr_t ins, logic tk, addr_t tgt);
        resolve_t r;
        r.valid = 1'b1;
        r.pc = pc;
        r.instr = ins;
        r.taken = tk;
        r.target = tgt;
        return r;
    endfunction

    function automatic resolve_t res_slot(int idx, logic tk, addr_t tgt);
        return make_res(pool_pc[idx], pool_instr[idx], tk, tgt);
    endfunction

    task automatic drive(int fidx, resolve_t res, logic flush_in, logic last);
        @(posedge CLK);
        #1;
        fetch.pc    = pool_pc[fidx];
        fetch.instr = pool_instr[fidx];
        resolve     = res;
        FLUSH       = flush_in;
        test_id     = cur_test;
        test_end    = last;
        phase_cycles++;
    endtask

    task automatic fetch_slot(int idx);
        drive(idx, '0, 1'b0, 1'b0);
    endtask

    task automatic resolve_at(resolve_t res);
        drive(ALU_IDX, res, 1'b0, 1'b0);
    endtask

    task automatic start_test(int n);
        cur_test = n;
        phase_cycles = 0;
    endtask

    task automatic close_test();
        while (phase_cycles < PHASE_LEN - 1) begin
            fetch_slot(rand_slot());
        end
        drive(ALU_IDX, '0, 1'b0, 1'b1);
    endtask

    task automatic cold_tables();
        start_test(1);
        for (int i = 0; i < POOL_SIZE; i++) begin
            fetch_slot(i);
        end
        // Taken branch resolutions at the ALU PC give it a BTB hit and a taken counter
        resolve_at(make_res(pool_pc[ALU_IDX], pool_instr[0], 1'b1, TGT_A));
        resolve_at(make_res(pool_pc[ALU_IDX], pool_instr[0], 1'b1, TGT_A));
        fetch_slot(ALU_IDX);
        close_test();
    endtask

    task automatic train_counters();
        start_test(2);
        fetch_slot(0);
        resolve_at(res_slot(0, 1'b1, TGT_A));
        // One taken step from WEAK_NT already predicts taken
        fetch_slot(0);
        resolve_at(res_slot(0, 1'b1, TGT_A));
        resolve_at(res_slot(0, 1'b0, TGT_B));
        fetch_slot(0);
        resolve_at(res_slot(0, 1'b0, TGT_B));
        fetch_slot(0);
        close_test();
    endtask

    task automatic jump_hits();
        start_test(3);
        // Branch resolutions at the jump's PC push its counter to strongly not taken
        resolve_at(make_res(pool_pc[2], pool_instr[0], 1'b0, '0));
        resolve_at(make_res(pool_pc[2], pool_instr[0], 1'b0, '0));
        fetch_slot(2);
        resolve_at(res_slot(2, 1'b1, TGT_C));
        fetch_slot(2);
        resolve_at(res_slot(2, 1'b1, TGT_C));
        resolve_at(res_slot(2, 1'b0, TGT_C));
        fetch_slot(2);
        // Jump resolutions at a branch PC fill its BTB entry but keep its counter at WEAK_NT
        resolve_at(make_res(pool_pc[1], pool_instr[2], 1'b1, TGT_C));
        resolve_at(make_res(pool_pc[1], pool_instr[2], 1'b1, TGT_C));
        fetch_slot(1);
        close_test();
    endtask

    task automatic tag_alias();
        start_test(4);
        resolve_at(res_slot(0, 1'b1, TGT_D));
        resolve_at(res_slot(0, 1'b1, TGT_D));
        fetch_slot(0);
        fetch_slot(12);
        fetch_slot(14);
        // Slot 14 takes over the entry that slot 2 held
        resolve_at(res_slot(14, 1'b1, TGT_E));
        fetch_slot(2);
        fetch_slot(14);
        close_test();
    endtask

    task automatic flush_tables();
        start_test(5);
        resolve_at(res_slot(1, 1'b1, TGT_F));
        fetch_slot(0);
        fetch_slot(1);
        fetch_slot(14);
        drive(0, res_slot(5, 1'b1, TGT_G), 1'b1, 1'b0);
        fetch_slot(0);
        fetch_slot(1);
        fetch_slot(14);
        fetch_slot(5);
        close_test();
    endtask

    task automatic random_mix();
        logic [31:0] r;
        int          fidx;
        int          ridx;
        resolve_t    res;
        start_test(6);
        while (phase_cycles < PHASE_LEN - 1) begin
            r = next_rand();
            fidx = int'(r[31:28]);
            // Half of the resolutions land on the slot fetched in the same cycle
            ridx = r[27] ? fidx : int'(r[26:23]);
            res = '0;
            if (r[22]) begin
                res = res_slot(ridx, r[21], rand_target());
            end
            drive(fidx, res, r[20:15] == 6'd0, 1'b0);
        end
        close_test();
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        fetch = '0;
        resolve = '0;
        FLUSH = 1'b0;
        test_id = 0;
        test_end = 1'b0;
        cur_test = 0;
        phase_cycles = 0;
        assert_fails = 0;
        rng_state = SEED;
        build_pool();
        wait (RESET === 1'b1);
        cold_tables();
        train_counters();
        jump_hits();
        tag_alias();
        flush_tables();
        random_mix();
        // The last test line is out, the final fetch is still compared
        @(posedge CLK);
        #1;
        test_end = 1'b0;
        repeat (2) @(posedge CLK);
        assert_fails = UUT.u_chk.reset_fails + UUT.u_chk.flush_fails + UUT.u_chk.target_fails;
        $display("%0d checks, %0d mismatches, %0d assertion failures",
                 total_checks, total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* bench/tb_checker.sv */
module tb_checker (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                FLUSH,
    input  bpred_pkg::fetch_t   fetch,
    input  bpred_pkg::resolve_t resolve,
    input  bpred_pkg::pred_t    pred,
    input  int                  test_id,
    input  logic                test_end,
    output int                  total_checks,
    output int                  total_errors
);

    import bpred_pkg::*;

    logic     btb_v   [BTB_ENTRIES];
    btb_tag_t btb_tg  [BTB_ENTRIES];
    addr_t    btb_tgt [BTB_ENTRIES];
    // Counter 0 is strongly not taken, 3 strongly taken, 1 the cleared state
    int       ctr     [PHT_ENTRIES];

    pred_t expected = '0;
    int    test_checks = 0;
    int    test_errors = 0;

    function automatic string test_name(int n);
        case (n)
            1: return "cold_tables";
            2: return "counter_training";
            3: return "jumps";
            4: return "tag_aliasing";
            5: return "flush";
            6: return "random_mix";
            default: return "reset";
        endcase
    endfunction

    function automatic logic cond_branch(instr_t ins);
        return (ins[31:26] == OP_BEQ) || (ins[31:26] == OP_BNE) || (ins[31:26] == OP_BLEZ)
            || (ins[31:26] == OP_BGTZ) || (ins[31:26] == OP_REGIMM);
    endfunction

    function automatic logic jump_instr(instr_t ins);
        return (ins[31:26] == OP_J) || (ins[31:26] == OP_JAL)
            || ((ins[31:26] == OP_SPECIAL) && (ins[5:0] == FN_JR));
    endfunction

    task automatic clear_model();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            btb_v[i] = 1'b0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            ctr[i] = 1;
        end
    endtask

    function automatic pred_t model_predict(fetch_t f);
        btb_idx_t bi;
        pht_idx_t pi;
        logic     hit;
        pred_t    p;
        bi = f.pc[2 +: BTB_IDX_W];
        pi = f.pc[2 +: PHT_IDX_W];
        hit = btb_v[bi] && (btb_tg[bi] == f.pc[31 -: BTB_TAG_W]);
        p.taken = hit && (jump_instr(f.instr) || (cond_branch(f.instr) && ctr[pi] >= 2));
        p.target = p.taken ? btb_tgt[bi] : '0;
        return p;
    endfunction

    task automatic apply_resolution(resolve_t r);
        btb_idx_t bi;
        pht_idx_t pi;
        bi = r.pc[2 +: BTB_IDX_W];
        pi = r.pc[2 +: PHT_IDX_W];
        if (r.valid && r.taken && (cond_branch(r.instr) || jump_instr(r.instr))) begin
            btb_v[bi] = 1'b1;
            btb_tg[bi] = r.pc[31 -: BTB_TAG_W];
            btb_tgt[bi] = r.target;
        end
        if (r.valid && cond_branch(r.instr)) begin
            if (r.taken && ctr[pi] < 3) begin
                ctr[pi] = ctr[pi] + 1;
            end else if (!r.taken && ctr[pi] > 0) begin
                ctr[pi] = ctr[pi] - 1;
            end
        end
    endtask

    // Sampling at the falling edge sees inputs and pred settled
    always @(negedge CLK) begin
        if (!RESET) begin
            clear_model();
            expected = '0;
            test_checks = 0;
            test_errors = 0;
            total_checks = 0;
            total_errors = 0;
        end else begin
            test_checks++;
            total_checks++;
            if (pred !== expected) begin
                test_errors++;
                total_errors++;
                $display("error %s: expected taken=%0b target=%h, actual taken=%0b target=%h",
                         test_name(test_id), expected.taken, expected.target,
                         pred.taken, pred.target);
            end
            if (test_end) begin
                $display("test %0d %s: %0d checks, %0d mismatches",
                         test_id, test_name(test_id), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            // Lookup first, then the update that the coming edge applies
            if (FLUSH) begin
                clear_model();
                expected = '0;
            end else begin
                expected = model_predict(fetch);
                apply_resolution(resolve);
            end
        end
    end

endmodule

/* bench/tb_clock.sv */
module tb_clock (
    output logic CLK,
    output logic RESET
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    // Release comes just after an edge so it never coincides with one
    initial begin
        RESET = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET = 1'b1;
    end

endmodule

/* bench/bpred_chk.sv */
module bpred_chk (
    input logic             CLK,
    input logic             RESET,
    input logic             FLUSH,
    input bpred_pkg::pred_t pred
);

    int reset_fails = 0;
    int flush_fails = 0;
    int target_fails = 0;

    // The first predictions after reset come from cleared tables
    assert property (@(posedge CLK) $rose(RESET) |=> !pred.taken)
        else begin
            reset_fails++;
            $error("prediction taken one cycle after reset release");
        end

    assert property (@(posedge CLK) disable iff (!RESET) FLUSH |=> !pred.taken)
        else begin
            flush_fails++;
            $error("prediction taken in the cycle after FLUSH");
        end

    // Stored targets are never zero, so a taken prediction always carries one
    assert property (@(posedge CLK) disable iff (!RESET) pred.taken |-> (pred.target != '0))
        else begin
            target_fails++;
            $error("taken prediction with a zero target");
        end

endmodule

bind bimodal_top bpred_chk u_chk (
    .CLK   (CLK),
    .RESET (RESET),
    .FLUSH (FLUSH),
    .pred  (pred)
);

/* rtl/bimodal_top.sv */
module bimodal_top (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 FLUSH,
    input  bpred_pkg::fetch_t    fetch,
    input  bpred_pkg::resolve_t  resolve,
    output bpred_pkg::pred_t     pred
);

    import bpred_pkg::*;

    logic  fetch_branch;
    logic  fetch_jump;
    logic  res_branch;
    logic  res_jump;

    logic  btb_wr_en;
    logic  pht_upd_en;

    logic  btb_hit;
    addr_t btb_target;
    logic  pht_taken;

    instr_class fetch_class (
        .instr     (fetch.instr),
        .is_branch (fetch_branch),
        .is_jump   (fetch_jump)
    );

    instr_class res_class (
        .instr     (resolve.instr),
        .is_branch (res_branch),
        .is_jump   (res_jump)
    );

    // A resolution presented together with FLUSH is dropped
    assign btb_wr_en  = resolve.valid && (res_branch || res_jump) && resolve.taken && !FLUSH;

    // Jumps are always taken, so only conditional branches train the counters
    assign pht_upd_en = resolve.valid && res_branch && !FLUSH;

    btb u_btb (
        .CLK       (CLK),
        .RESET     (RESET),
        .flush     (FLUSH),
        .lookup_pc (fetch.pc),
        .hit       (btb_hit),
        .target    (btb_target),
        .wr_en     (btb_wr_en),
        .wr_pc     (resolve.pc),
        .wr_target (resolve.target)
    );

    pht u_pht (
        .CLK           (CLK),
        .RESET         (RESET),
        .flush         (FLUSH),
        .lookup_pc     (fetch.pc),
        .predict_taken (pht_taken),
        .upd_en        (pht_upd_en),
        .upd_pc        (resolve.pc),
        .upd_taken     (resolve.taken)
    );

    pred_combine u_combine (
        .CLK        (CLK),
        .RESET      (RESET),
        .flush      (FLUSH),
        .is_branch  (fetch_branch),
        .is_jump    (fetch_jump),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .pht_taken  (pht_taken),
        .pred       (pred)
    );

endmodule

/* rtl/pred_combine.sv */
module pred_combine (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               flush,
    input  logic               is_branch,
    input  logic               is_jump,
    input  logic               btb_hit,
    input  bpred_pkg::addr_t   btb_target,
    input  logic               pht_taken,
    output bpred_pkg::pred_t   pred
);

    import bpred_pkg::*;

    logic  taken_c;
    pred_t pred_c;

    // A jump only needs a BTB entry; a conditional branch also needs the counter
    assign taken_c = btb_hit && (is_jump || (is_branch && pht_taken));

    // Not-taken predictions carry a zero target
    assign pred_c.taken  = taken_c;
    assign pred_c.target = taken_c ? btb_target : '0;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pred <= '0;
        end else if (flush) begin
            pred <= '0;
        end else begin
            pred <= pred_c;
        end
    end

endmodule

/* rtl/pht.sv */
module pht (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             flush,
    input  bpred_pkg::addr_t lookup_pc,
    output logic             predict_taken,
    input  logic             upd_en,
    input  bpred_pkg::addr_t upd_pc,
    input  logic             upd_taken
);

    import bpred_pkg::*;

    ctr_t ctr_mem [PHT_ENTRIES];

    pht_idx_t rd_idx;
    pht_idx_t upd_idx;
    ctr_t     rd_ctr;
    ctr_t     upd_next;

    // One step toward the resolved direction, held at either end
    function automatic ctr_t sat_step(ctr_t cur, logic taken);
        ctr_t nxt;
        case (cur)
            STRONG_NT: nxt = taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    assign rd_idx  = pht_index(lookup_pc);
    assign upd_idx = pht_index(upd_pc);

    assign rd_ctr = ctr_mem[rd_idx];

    // Upper counter bit set means one of the two taken states
    assign predict_taken = (rd_ctr == WEAK_T) || (rd_ctr == STRONG_T);

    assign upd_next = sat_step(ctr_mem[upd_idx], upd_taken);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_mem[i] <= WEAK_NT;
            end
        end else if (flush) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_mem[i] <= WEAK_NT;
            end
        end else if (upd_en) begin
            ctr_mem[upd_idx] <= upd_next;
        end
    end

endmodule

/* rtl/btb.sv */
module btb (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             flush,
    input  bpred_pkg::addr_t lookup_pc,
    output logic             hit,
    output bpred_pkg::addr_t target,
    input  logic             wr_en,
    input  bpred_pkg::addr_t wr_pc,
    input  bpred_pkg::addr_t wr_target
);

    import bpred_pkg::*;

    // Stored part of an entry; the valid bit lives apart so that it can be cleared at once
    typedef struct packed {
        btb_tag_t tag;
        addr_t    target;
    } entry_t;

    logic [BTB_ENTRIES-1:0] valid_q;
    entry_t                 entry_mem [BTB_ENTRIES];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    entry_t   rd_entry;

    btb_idx_t wr_idx;
    entry_t   wr_entry;

    assign rd_idx   = btb_index(lookup_pc);
    assign rd_tag   = btb_tag(lookup_pc);
    assign rd_entry = entry_mem[rd_idx];

    // Lookup reads the state from before the edge, so a write to the
    // same slot this cycle is only seen by the next fetch
    assign hit    = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
    assign target = rd_entry.target;

    assign wr_idx          = btb_index(wr_pc);
    assign wr_entry.tag    = btb_tag(wr_pc);
    assign wr_entry.target = wr_target;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target need no clearing since valid_q masks stale contents
    always_ff @(posedge CLK) begin
        if (wr_en && !flush) begin
            entry_mem[wr_idx] <= wr_entry;
        end
    end

endmodule

/* rtl/instr_class.sv */
module instr_class (
    input  bpred_pkg::instr_t instr,
    output logic              is_branch,
    output logic              is_jump
);

    import bpred_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            // REGIMM holds BLTZ, BGEZ and their linking forms, all conditional
            OP_REGIMM,
            OP_BEQ,
            OP_BNE,
            OP_BLEZ,
            OP_BGTZ: begin
                is_branch = 1'b1;
            end
            OP_J,
            OP_JAL: begin
                is_jump = 1'b1;
            end
            OP_SPECIAL: begin
                // Only a register jump among the R-type functions redirects fetch
                is_jump = (funct == FN_JR);
            end
            default: begin
                is_branch = 1'b0;
                is_jump   = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/bpred_pkg.sv */
package bpred_pkg;

    localparam int ADDR_W = 32;
    localparam int BTB_IDX_W = 6;
    localparam int PHT_IDX_W = 8;

    // Tag covers the PC bits above the index
    localparam int BTB_TAG_W = ADDR_W - 2 - BTB_IDX_W;

    localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
    localparam int PHT_ENTRIES = 1 << PHT_IDX_W;

    // Primary opcode field, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;

    // Function field of an R-type instruction, instr[5:0]
    localparam logic [5:0] FN_JR = 6'b001000;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [PHT_IDX_W-1:0] pht_idx_t;

    // Two-bit saturating direction counter, WEAK_NT after reset
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
        logic   taken;
        addr_t  target;
    } resolve_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } pred_t;

    // Both tables index with the word address bits directly above the byte offset
    function automatic btb_idx_t btb_index(addr_t pc);
        return pc[2 +: BTB_IDX_W];
    endfunction

    function automatic btb_tag_t btb_tag(addr_t pc);
        return pc[ADDR_W-1 -: BTB_TAG_W];
    endfunction

    function automatic pht_idx_t pht_index(addr_t pc);
        return pc[2 +: PHT_IDX_W];
    endfunction

endpackage
